/* all.f */
verilog/rvCorePkg.sv
verilog/muxKeyWithDefault.sv
verilog/rvController.sv
verilog/immGen.sv
verilog/rvAlu.sv
verilog/regFile.sv
verilog/loadStoreUnit.sv
verilog/pcUnit.sv
verilog/rvCore.sv
verification/rvCoreTb.sv

/* verification/rvCoreTb.sv */
//************************************************************
// Testbench for the single-cycle RV32I core
// Random program run against an instruction-set model
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

    import rvCorePkg::*;

    localparam wordT resetVector = 32'h8000_0000;
    localparam int   numInstr    = 400;
    localparam int   numSeeds    = 13;                      // lui seeds at the start
    localparam int   cycleLimit  = 8 + 2 + numInstr + 50;
    localparam wordT nopInstr    = 32'h0000_0013;           // addi x0, x0, 0
    localparam wordT idleStore   = 32'h0000_2023;           // sw x0, 0(x0)
    localparam wordT idleLui     = 32'h1234_50B7;           // lui x1, 0x12345

    logic    clk;
    logic    arstN;
    wordT    instrAddr;
    wordT    instr;
    wordT    dataAddr;
    wordT    writeData;
    byteEnT  byteEn;
    logic    memWrite;
    wordT    readData;
    logic    commitValid;
    wordT    commitPc;
    regIdxT  commitRd;
    wordT    commitData;

    // Program image plus the fields each word was built from
    wordT    imem [numInstr];
    opcodeT  progOp [numInstr];
    funct3T  progF3 [numInstr];
    logic    progAlt [numInstr];    // sub / srai / sra
    regIdxT  progRd [numInstr];
    regIdxT  progRs1 [numInstr];
    regIdxT  progRs2 [numInstr];
    wordT    progImm [numInstr];

    wordT       dmem [256];         // Memory seen by the DUT
    logic [7:0] modelMem [1024];    // Reference byte memory
    wordT       xreg [32];
    wordT       mPc;

    // Expected results of the current instruction
    int      cat;
    int      prevCat;
    logic    regWr;
    logic    isStore;
    regIdxT  expRd;
    wordT    expData;
    wordT    expAddr;
    wordT    expWdata;
    byteEnT  expBe;
    wordT    nextPc;
    wordT    laneMask;

    int      checks [6];
    int      errors [6];
    string   testNames [6];
    int      curTest;
    int      cycles = 0;
    int      seed;
    int      totalChecks;
    int      totalErrors;

    rvCore #(.resetVector(resetVector)) uut (
        .clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .writeData(writeData), .byteEn(byteEn), .memWrite(memWrite),
        .readData(readData), .commitValid(commitValid), .commitPc(commitPc),
        .commitRd(commitRd), .commitData(commitData)
    );

    always #20 clk = ~clk;

    // Byte-lane writes on the rising edge
    always @(posedge clk) begin
        if (memWrite) begin
            for (int k = 0; k < 4; k++) begin
                if (byteEn[k]) dmem[dataAddr[9:2]][8*k +: 8] <= writeData[8*k +: 8];
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        checks[curTest]++;
        if (got !== exp) begin
            errors[curTest]++;
            $display("Mismatch %s at pc %h: got %h, expected %h", name, mPc, got, exp);
        end
    endtask

    task automatic checkRegIdx(input string name, input regIdxT got, input regIdxT exp);
        checks[curTest]++;
        if (got !== exp) begin
            errors[curTest]++;
            $display("Mismatch %s at pc %h: got %h, expected %h", name, mPc, got, exp);
        end
    endtask

    task automatic checkByteEn(input string name, input byteEnT got, input byteEnT exp);
        checks[curTest]++;
        if (got !== exp) begin
            errors[curTest]++;
            $display("Mismatch %s at pc %h: got %h, expected %h", name, mPc, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks[curTest]++;
        if (got !== exp) begin
            errors[curTest]++;
            $display("Mismatch %s at pc %h: got %h, expected %h", name, mPc, got, exp);
        end
    endtask

    // Assemble the ISA encoding from the stored fields
    function automatic wordT encode(input int i);
        wordT imm;
        imm = progImm[i];
        case (progOp[i])
            opOp: encode = {1'b0, progAlt[i], 5'b0, progRs2[i], progRs1[i], progF3[i],
                            progRd[i], opOp};
            opOpImm: begin
                if (progF3[i] == 3'd1 || progF3[i] == 3'd5)
                    encode = {1'b0, progAlt[i], 5'b0, imm[4:0], progRs1[i], progF3[i],
                              progRd[i], opOpImm};
                else
                    encode = {imm[11:0], progRs1[i], progF3[i], progRd[i], opOpImm};
            end
            opLoad, opJalr: encode = {imm[11:0], progRs1[i], progF3[i], progRd[i], progOp[i]};
            opStore: encode = {imm[11:5], progRs2[i], progRs1[i], progF3[i], imm[4:0], opStore};
            opBranch: encode = {imm[12], imm[10:5], progRs2[i], progRs1[i], progF3[i],
                                imm[4:1], imm[11], opBranch};
            opJal: encode = {imm[20], imm[10:1], imm[11], imm[19:12], progRd[i], opJal};
            default: encode = {imm[31:12], progRd[i], progOp[i]};   // lui, auipc
        endcase
    endfunction

    // One random instruction, control flow only forward
    task automatic genInstr(input int i);
        int   kind;
        int   size;
        int   span;
        int   tgt;
        int   r3;
        wordT r;
        r          = $urandom;
        progAlt[i] = 1'b0;
        progF3[i]  = 3'd0;
        progRd[i]  = regIdxT'($urandom % 31);  // x31 keeps the program base
        progRs1[i] = regIdxT'($urandom % 32);
        progRs2[i] = regIdxT'($urandom % 32);
        progImm[i] = {{20{r[11]}}, r[11:0]};
        kind       = $urandom % 10;
        span       = numInstr - 1 - i;
        tgt        = 1 + $urandom % ((span < 8) ? ((span < 1) ? 1 : span) : 8);
        if (i == numInstr - 1 && (kind == 7 || kind == 8)) kind = 3;
        if (i < numSeeds) begin
            progOp[i]  = opLui;
            progRd[i]  = (i == 0) ? 5'd31 : regIdxT'(i);
            progImm[i] = (i == 0) ? resetVector : {r[31:12], 12'b0};
        end else begin
            case (kind)
                0, 1, 2: begin
                    progOp[i]  = opOp;
                    progF3[i]  = funct3T'($urandom % 8);
                    progAlt[i] = (progF3[i] == 3'd0 || progF3[i] == 3'd5) && ($urandom % 2);
                end
                3, 4: begin
                    progOp[i] = opOpImm;
                    progF3[i] = funct3T'($urandom % 8);
                    if (progF3[i] == 3'd1 || progF3[i] == 3'd5) begin
                        progImm[i] = $urandom % 32;     // Shift amount
                        progAlt[i] = (progF3[i] == 3'd5) && ($urandom % 2);
                    end
                end
                5, 6: begin
                    r3         = $urandom % ((kind == 5) ? 5 : 3);
                    progOp[i]  = (kind == 5) ? opLoad : opStore;
                    progF3[i]  = funct3T'((r3 > 2) ? r3 + 1 : r3);  // lbu, lhu
                    size       = 1 << progF3[i][1:0];
                    progRs1[i] = 5'd0;                  // Absolute address in 1 KiB
                    progImm[i] = ($urandom % 1024) & ~(size - 1);
                end
                7: begin
                    progOp[i]  = opBranch;
                    if ($urandom % 2) progRs2[i] = progRs1[i];  // Force taken
                    progImm[i] = tgt * 4;
                end
                8: begin
                    if ($urandom % 2) begin
                        progOp[i]  = opJal;
                        progImm[i] = tgt * 4;
                    end else begin
                        progOp[i]  = opJalr;
                        progRs1[i] = 5'd31;
                        progImm[i] = (i + tgt) * 4 + $urandom % 2;  // Odd target too
                    end
                end
                default: begin
                    progOp[i]  = ($urandom % 2) ? opLui : opAuipc;
                    progImm[i] = {r[31:12], 12'b0};
                end
            endcase
        end
        imem[i] = encode(i);
    endtask

    function automatic wordT fetchInstr(input wordT addr);
        wordT idx;
        idx = (addr - resetVector) >> 2;
        if (idx < numInstr) return imem[idx];
        return nopInstr;
    endfunction

    // Execute the instruction at mPc on the reference state
    task automatic stepModel();
        int   i;
        int   size;
        wordT a;
        wordT b;
        wordT opB;
        wordT res;
        i       = (mPc - resetVector) >> 2;
        a       = xreg[progRs1[i]];
        b       = xreg[progRs2[i]];
        opB     = (progOp[i] == opOp) ? b : progImm[i];
        expAddr = a + progImm[i];
        size    = 1 << progF3[i][1:0];
        nextPc  = mPc + 4;
        regWr   = 1'b1;
        isStore = 1'b0;
        expBe   = '0;
        res     = '0;
        case (progOp[i])
            opOp, opOpImm: begin
                cat = 1;
                case (progF3[i])
                    3'd0: res = (progOp[i] == opOp && progAlt[i]) ? a - opB : a + opB;
                    3'd1: res = a << opB[4:0];
                    3'd2: res = ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
                    3'd3: res = (a < opB) ? 32'd1 : 32'd0;
                    3'd4: res = a ^ opB;
                    3'd5: res = progAlt[i] ? wordT'($signed(a) >>> opB[4:0]) : a >> opB[4:0];
                    3'd6: res = a | opB;
                    default: res = a & opB;
                endcase
            end
            opLoad: begin
                cat = 2;
                for (int k = size - 1; k >= 0; k--) res = (res << 8) | modelMem[expAddr[9:0] + k];
                if (!progF3[i][2] && size == 1) res = {{24{res[7]}}, res[7:0]};
                if (!progF3[i][2] && size == 2) res = {{16{res[15]}}, res[15:0]};
            end
            opStore: begin
                cat      = 3;
                regWr    = 1'b0;
                isStore  = 1'b1;
                expBe    = byteEnT'(((1 << size) - 1) << expAddr[1:0]);
                expWdata = b << (8 * expAddr[1:0]);
                for (int k = 0; k < 4; k++) begin
                    if (expBe[k]) modelMem[{expAddr[9:2], 2'(k)}] = expWdata[8*k +: 8];
                end
            end
            opBranch: begin
                cat   = 4;
                regWr = 1'b0;
                if (a == b) nextPc = mPc + progImm[i];
            end
            opJal: begin
                cat    = 4;
                res    = mPc + 4;
                nextPc = mPc + progImm[i];
            end
            opJalr: begin
                cat    = 4;
                res    = mPc + 4;
                nextPc = (a + progImm[i]) & ~32'd1;
            end
            opLui: begin
                cat = 5;
                res = progImm[i];
            end
            default: begin
                cat = 5;
                res = mPc + progImm[i];     // auipc
            end
        endcase
        expRd   = regWr ? progRd[i] : 5'd0;
        expData = res;
        if (regWr && progRd[i] != 5'd0) xreg[progRd[i]] = res;
    endtask

    // Store and register write both gated while not running
    task automatic checkResetState();
        checkBit("commitValid", commitValid, 1'b0);
        checkBit("memWrite", memWrite, 1'b0);
        checkRegIdx("commitRd", commitRd, 5'd0);
        checkWord("instrAddr", instrAddr, resetVector);
    endtask

    initial begin
        seed = 50523;
        void'($urandom(seed));
        testNames = '{"Reset", "Arithmetic and logic", "Loads", "Stores",
                      "Control flow", "Upper immediates"};
        clk      = 1'b0;
        arstN    = 1'b0;
        instr    = idleStore;   // Must not reach memory during reset
        readData = '0;
        curTest  = 0;
        prevCat  = 1;
        mPc      = resetVector;
        for (int k = 0; k < 6; k++) begin
            checks[k] = 0;
            errors[k] = 0;
        end
        for (int k = 0; k < 32; k++) xreg[k] = '0;
        for (int a = 0; a < 1024; a++) begin
            modelMem[a]                = 8'($urandom);
            dmem[a >> 2][8*(a%4) +: 8] = modelMem[a];
        end
        for (int i = 0; i < numInstr; i++) genInstr(i);

        repeat (7) begin
            @(negedge clk);
            #2;
            checkResetState();
        end
        @(negedge clk);
        arstN = 1'b1;
        instr = idleLui;        // Register write must stay gated
        #2;
        checkResetState();      // Still idle until the next edge
        $display("%-22s %0d checks, %0d errors", testNames[0], checks[0], errors[0]);

        while (((mPc - resetVector) >> 2) < numInstr) begin
            @(negedge clk);
            instr = fetchInstr(instrAddr);
            #2;
            readData = dmem[dataAddr[9:2]];
            #2;
            curTest = prevCat;  // Next-PC belongs to the previous instruction
            checkWord("commitPc", commitPc, mPc);
            stepModel();
            curTest = cat;
            checkBit("commitValid", commitValid, 1'b1);
            checkRegIdx("commitRd", commitRd, expRd);
            if (regWr) checkWord("commitData", commitData, expData);
            checkBit("memWrite", memWrite, isStore);
            checkByteEn("byteEn", byteEn, expBe);
            if (isStore) begin
                laneMask = {{8{expBe[3]}}, {8{expBe[2]}}, {8{expBe[1]}}, {8{expBe[0]}}};
                checkWord("dataAddr", dataAddr, {expAddr[31:2], 2'b00});
                checkWord("writeData", writeData & laneMask, expWdata & laneMask);
            end
            mPc     = nextPc;
            prevCat = cat;
        end
        @(negedge clk);
        #4;
        curTest = prevCat;
        checkWord("commitPc", commitPc, mPc);

        totalChecks = 0;
        totalErrors = 0;
        for (int t = 0; t < 6; t++) begin
            if (t > 0) $display("%-22s %0d checks, %0d errors", testNames[t], checks[t], errors[t]);
            totalChecks += checks[t];
            totalErrors += errors[t];
        end
        $display("Total: %0d checks, %0d errors", totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/immGen.sv */
//************************************************************
// Immediate generator for I, S, B, U and J formats
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  rvCorePkg::wordT   instr,
    input  rvCorePkg::opcodeT opcode,
    output rvCorePkg::wordT   imm
);

    import rvCorePkg::*;

    always_comb begin
        case (opcode)
            opLoad, opOpImm, opJalr: begin
                imm = {{20{instr[31]}}, instr[31:20]};  // I
            end
            opStore: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            opBranch: begin
                // B format, bit 0 implied zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            opLui, opAuipc: begin
                imm = {instr[31:12], 12'b0};            // U
            end
            opJal: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};             // J
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/loadStoreUnit.sv */
//************************************************************
// Load/store lane steering
// Byte enables and store lanes, load extract and extend
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
    input  rvCorePkg::wordT    addr,
    input  rvCorePkg::wordT    storeValue,
    input  rvCorePkg::dataLenT dataLen,
    input  logic               dataSign,
    input  logic               storeEn,
    input  rvCorePkg::wordT    readData,
    output rvCorePkg::byteEnT  byteEn,
    output rvCorePkg::wordT    writeData,
    output logic               memWrite,
    output rvCorePkg::wordT    loadValue
);

    import rvCorePkg::*;

    logic [1:0] offset;     // Byte lane within the word
    wordT       shifted;

    assign offset   = addr[1:0];
    assign memWrite = storeEn;

    // Replicate store data so any lane holds it
    always_comb begin
        byteEn    = '0;
        writeData = storeValue;
        case (dataLen)
            3'b001: begin
                writeData = {4{storeValue[7:0]}};
                if (storeEn) byteEn = byteEnT'(4'b0001 << offset);
            end
            3'b010: begin
                writeData = {2{storeValue[15:0]}};
                if (storeEn) byteEn = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                if (storeEn) byteEn = 4'b1111;      // sw
            end
        endcase
    end

    assign shifted = readData >> {offset, 3'b000};

    always_comb begin
        case (dataLen)
            3'b001:  loadValue = {{24{dataSign & shifted[7]}}, shifted[7:0]};
            3'b010:  loadValue = {{16{dataSign & shifted[15]}}, shifted[15:0]};
            default: loadValue = shifted;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/muxKeyWithDefault.sv */
//************************************************************
// Key-matching table selector with default output
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module muxKeyWithDefault #(
    parameter int numKeys   = 2,
    parameter int keyWidth  = 7,
    parameter int dataWidth = 1
) (
    output logic [dataWidth-1:0]                    out,
    input  logic [keyWidth-1:0]                     key,
    input  logic [dataWidth-1:0]                    defaultOut,
    input  logic [numKeys*(keyWidth+dataWidth)-1:0] lut     // {key, data} pairs
);

    localparam int entryW = keyWidth + dataWidth;

    always_comb begin
        out = defaultOut;   // No entry matched
        for (int i = 0; i < numKeys; i++) begin
            if (lut[i*entryW + dataWidth +: keyWidth] == key) begin
                out = lut[i*entryW +: dataWidth];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/pcUnit.sv */
//************************************************************
// Program counter with next-PC select and run flag
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
    parameter rvCorePkg::wordT resetVector = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            branch,
    input  logic            zero,
    input  rvCorePkg::jmpT  jmp,
    input  rvCorePkg::wordT imm,
    input  rvCorePkg::wordT aluSum,    // rs1 + imm for jalr
    output rvCorePkg::wordT pc,
    output rvCorePkg::wordT pcPlus4,
    output logic            running
);

    import rvCorePkg::*;

    wordT nextPc;

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        if (jmp == jmpJalr) nextPc = {aluSum[31:1], 1'b0};
        else if (jmp == jmpJal || (branch && zero)) nextPc = pc + imm;
        else nextPc = pcPlus4;  // Sequential and unsupported opcodes
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= resetVector;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (running) pc <= nextPc;  // Hold vector on first edge
        end
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
//************************************************************
// 32 x 32 register file, two read ports, x0 tied to zero
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              arstN,
    input  rvCorePkg::regIdxT rs1,
    input  rvCorePkg::regIdxT rs2,
    input  rvCorePkg::regIdxT rd,
    input  logic              writeEn,
    input  rvCorePkg::wordT   writeValue,
    output rvCorePkg::wordT   rs1Data,
    output rvCorePkg::wordT   rs2Data
);

    import rvCorePkg::*;

    wordT regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rd != '0) begin  // x0 stays zero
            regs[rd] <= writeValue;
        end
    end

    // Asynchronous reads
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

endmodule

`default_nettype wire

/* verilog/rvAlu.sv */
//************************************************************
// RV32I ALU with zero flag
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module rvAlu (
    input  rvCorePkg::wordT  opA,
    input  rvCorePkg::wordT  opB,
    input  rvCorePkg::aluOpT aluControl,
    output rvCorePkg::wordT  result,
    output logic             zero      // beq taken when set
);

    import rvCorePkg::*;

    logic [4:0] shamt;

    assign shamt = opB[4:0];   // Shift amount from low bits only

    always_comb begin
        case (aluControl)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluSll:   result = opA << shamt;
            aluSlt:   result = {31'b0, $signed(opA) < $signed(opB)};
            aluSltu:  result = {31'b0, opA < opB};
            aluXor:   result = opA ^ opB;
            aluSrl:   result = opA >> shamt;
            aluSra:   result = wordT'($signed(opA) >>> shamt);
            aluOr:    result = opA | opB;
            aluAnd:   result = opA & opB;
            aluPassB: result = opB;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* verilog/rvController.sv */
//************************************************************
// RV32I control decoder
// Opcode, func3 and func7 to datapath control levels
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module rvController (
    input  rvCorePkg::opcodeT  opcode,
    input  rvCorePkg::funct3T  func3,
    input  rvCorePkg::funct7T  func7,
    output rvCorePkg::wbSelT   memToReg,
    output logic               memWrite,
    output logic               branch,
    output rvCorePkg::jmpT     jmp,
    output rvCorePkg::aluOpT   aluControl,
    output logic               regWrite,
    output rvCorePkg::dataLenT dataLen,
    output logic               dataSign,
    output logic               aluSrc      // 1 selects the immediate
);

    import rvCorePkg::*;

    // Coarse ALU class per opcode, refined by func3/func7
    typedef logic [2:0] aluClassT;
    localparam aluClassT clsAdd  = 3'd0;   // Address calculation
    localparam aluClassT clsSub  = 3'd1;   // beq compare
    localparam aluClassT clsImm  = 3'd2;
    localparam aluClassT clsReg  = 3'd3;
    localparam aluClassT clsPass = 3'd4;   // lui
    localparam aluClassT clsNone = 3'd7;

    logic [1:0] memToRegRaw;
    logic [1:0] jmpRaw;
    logic       isBranchOp;
    aluClassT   aluClass;

    muxKeyWithDefault #(.numKeys(4), .keyWidth(7), .dataWidth(2)) memToRegMux (
        .out(memToRegRaw), .key(opcode), .defaultOut(wbAlu),
        .lut({opLoad, wbMem,        // lb lh lw lbu lhu
              opJalr, wbPcPlus4,
              opJal,  wbPcPlus4,
              opAuipc, wbPcImm})
    );
    assign memToReg = wbSelT'(memToRegRaw);

    muxKeyWithDefault #(.numKeys(1), .keyWidth(7), .dataWidth(1)) memWriteMux (
        .out(memWrite), .key(opcode), .defaultOut(1'b0),
        .lut({opStore, 1'b1})
    );

    muxKeyWithDefault #(.numKeys(1), .keyWidth(7), .dataWidth(1)) branchMux (
        .out(isBranchOp), .key(opcode), .defaultOut(1'b0),
        .lut({opBranch, 1'b1})
    );
    assign branch = isBranchOp && (func3 == 3'b000);   // beq only

    muxKeyWithDefault #(.numKeys(2), .keyWidth(7), .dataWidth(2)) jmpMux (
        .out(jmpRaw), .key(opcode), .defaultOut(jmpNone),
        .lut({opJal, jmpJal,
              opJalr, jmpJalr})
    );
    assign jmp = jmpT'(jmpRaw);

    muxKeyWithDefault #(.numKeys(7), .keyWidth(7), .dataWidth(3)) aluClassMux (
        .out(aluClass), .key(opcode), .defaultOut(clsNone),
        .lut({opLoad,   clsAdd,
              opStore,  clsAdd,
              opJalr,   clsAdd,     // rs1 + imm target
              opBranch, clsSub,
              opOpImm,  clsImm,
              opOp,     clsReg,
              opLui,    clsPass})
    );

    // Immediate operand for I, S, jalr and lui
    muxKeyWithDefault #(.numKeys(5), .keyWidth(7), .dataWidth(1)) aluSrcMux (
        .out(aluSrc), .key(opcode), .defaultOut(1'b0),
        .lut({opLoad, 1'b1, opOpImm, 1'b1, opStore, 1'b1, opJalr, 1'b1, opLui, 1'b1})
    );

    muxKeyWithDefault #(.numKeys(7), .keyWidth(7), .dataWidth(1)) regWriteMux (
        .out(regWrite), .key(opcode), .defaultOut(1'b0),
        .lut({opOp,    1'b1,
              opLoad,  1'b1,
              opOpImm, 1'b1,
              opJalr,  1'b1,
              opLui,   1'b1,
              opAuipc, 1'b1,
              opJal,   1'b1})
    );

    always_comb begin
        aluControl = aluNone;
        case (aluClass)
            clsAdd:  aluControl = aluAdd;
            clsSub:  aluControl = aluSub;
            clsPass: aluControl = aluPassB;
            clsImm, clsReg: begin
                case (func3)
                    3'b000: begin
                        if (aluClass == clsReg && func7[5]) aluControl = aluSub;
                        else aluControl = aluAdd;       // addi has no sub form
                    end
                    3'b001: aluControl = aluSll;
                    3'b010: aluControl = aluSlt;
                    3'b011: aluControl = aluSltu;
                    3'b100: aluControl = aluXor;
                    3'b101: begin
                        if (func7[5]) aluControl = aluSra;  // Also srai
                        else aluControl = aluSrl;
                    end
                    3'b110: aluControl = aluOr;
                    default: aluControl = aluAnd;
                endcase
            end
            default: aluControl = aluNone;
        endcase
    end

    // lb and lh extend the sign, lbu and lhu do not
    assign dataSign = (opcode == opLoad) && (func3 == 3'b000 || func3 == 3'b001);

    assign dataLen = (func3 == 3'b000 || func3 == 3'b100) ? 3'b001 :   // Byte
                     (func3 == 3'b001 || func3 == 3'b101) ? 3'b010 :   // Half
                     (func3 == 3'b010)                    ? 3'b100 :   // Word
                                                            3'b000;

endmodule

`default_nettype wire

/* verilog/rvCore.sv */
//************************************************************
// Single-cycle RV32I core top level
// Instruction, data and retirement trace ports
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
    parameter rvCorePkg::wordT resetVector = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               arstN,
    output rvCorePkg::wordT    instrAddr,
    input  rvCorePkg::wordT    instr,
    output rvCorePkg::wordT    dataAddr,
    output rvCorePkg::wordT    writeData,
    output rvCorePkg::byteEnT  byteEn,
    output logic               memWrite,
    input  rvCorePkg::wordT    readData,
    output logic               commitValid,
    output rvCorePkg::wordT    commitPc,
    output rvCorePkg::regIdxT  commitRd,
    output rvCorePkg::wordT    commitData
);

    import rvCorePkg::*;

    opcodeT  opcode;
    funct3T  func3;
    funct7T  func7;
    regIdxT  rd;
    regIdxT  rs1;
    regIdxT  rs2;
    wbSelT   memToReg;
    logic    memWriteCtl;
    logic    branch;
    jmpT     jmp;
    aluOpT   aluControl;
    logic    regWriteCtl;
    dataLenT dataLen;
    logic    dataSign;
    logic    aluSrc;
    wordT    imm;
    wordT    rs1Data;
    wordT    rs2Data;
    wordT    aluOpB;
    wordT    aluResult;
    logic    aluZero;
    wordT    loadValue;
    wordT    pc;
    wordT    pcPlus4;
    logic    running;
    logic    regWriteEn;
    wordT    wbValue;

    // Instruction fields
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign func3  = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign func7  = instr[31:25];

    rvController controller (
        .opcode(opcode), .func3(func3), .func7(func7),
        .memToReg(memToReg), .memWrite(memWriteCtl), .branch(branch), .jmp(jmp),
        .aluControl(aluControl), .regWrite(regWriteCtl), .dataLen(dataLen),
        .dataSign(dataSign), .aluSrc(aluSrc)
    );

    immGen immGenInst (.instr(instr), .opcode(opcode), .imm(imm));

    regFile regs (
        .clk(clk), .arstN(arstN), .rs1(rs1), .rs2(rs2), .rd(rd),
        .writeEn(regWriteEn), .writeValue(wbValue),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    assign aluOpB = aluSrc ? imm : rs2Data;

    rvAlu alu (
        .opA(rs1Data), .opB(aluOpB), .aluControl(aluControl),
        .result(aluResult), .zero(aluZero)
    );

    loadStoreUnit lsu (
        .addr(aluResult), .storeValue(rs2Data), .dataLen(dataLen), .dataSign(dataSign),
        .storeEn(memWriteCtl & running),    // No stores before the first fetch
        .readData(readData), .byteEn(byteEn), .writeData(writeData),
        .memWrite(memWrite), .loadValue(loadValue)
    );

    pcUnit #(.resetVector(resetVector)) pcu (
        .clk(clk), .arstN(arstN), .branch(branch), .zero(aluZero), .jmp(jmp),
        .imm(imm), .aluSum(aluResult), .pc(pc), .pcPlus4(pcPlus4), .running(running)
    );

    assign instrAddr = pc;
    assign dataAddr  = {aluResult[31:2], 2'b00};   // Word-aligned to memory

    // Writeback select
    always_comb begin
        case (memToReg)
            wbMem:     wbValue = loadValue;
            wbPcPlus4: wbValue = pcPlus4;
            wbPcImm:   wbValue = pc + imm;          // auipc
            default:   wbValue = aluResult;
        endcase
    end

    assign regWriteEn = regWriteCtl & running;

    // Retirement trace
    assign commitValid = running;
    assign commitPc    = pc;
    assign commitRd    = regWriteEn ? rd : '0;
    assign commitData  = wbValue;

endmodule

`default_nettype wire

/* verilog/rvCorePkg.sv */
//************************************************************
// RV32I core shared types
// Word, index and control typedefs, ALU ops, opcodes
//************************************************************
`default_nettype none

package rvCorePkg;

    typedef logic [31:0] wordT;     // Data and address word
    typedef logic [4:0]  regIdxT;   // x0..x31
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;
    typedef logic [6:0]  funct7T;
    typedef logic [3:0]  byteEnT;   // One bit per byte lane
    typedef logic [2:0]  dataLenT;  // One-hot 1, 2 or 4 bytes

    // Writeback source
    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbPcPlus4,  // Link value of jal and jalr
        wbPcImm     // auipc
    } wbSelT;

    typedef enum logic [1:0] {
        jmpNone,
        jmpJal,
        jmpJalr
    } jmpT;

    typedef enum logic [3:0] {
        aluAdd   = 4'h0,
        aluSub   = 4'h1,
        aluSll   = 4'h2,
        aluSlt   = 4'h3,
        aluSltu  = 4'h4,
        aluXor   = 4'h5,
        aluSrl   = 4'h6,
        aluSra   = 4'h7,
        aluOr    = 4'h8,
        aluAnd   = 4'h9,
        aluPassB = 4'hA,    // lui
        aluNone  = 4'hF
    } aluOpT;

    // Major opcodes of the base ISA
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opOpImm  = 7'b0010011;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opOp     = 7'b0110011;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opJal    = 7'b1101111;

endpackage

`default_nettype wire
